//--- include/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// execute stage widths

`define EXE_XLEN       32  // data word
`define EXE_REG_ADDR_W 5   // gpr index
`define EXE_IMM_W      16  // instruction immediate
`define EXE_STRB_W     4   // byte lanes per word
`define EXE_LANE_W     2   // byte offset inside a word

`endif

//--- hw/exe_pkg.sv
`include "exe_settings.svh"

package exe_pkg;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_slt  = 3'd2,
        op_sltu = 3'd3,
        op_and  = 3'd4,
        op_or   = 3'd5,
        op_xor  = 3'd6,
        op_lui  = 3'd7
    } alu_op_e;

    // one-hot access kind
    typedef struct packed {
        logic right;  // swr / lwr
        logic left;   // swl / lwl
        logic half;
        logic byte_;
        logic word;
    } ls_type_t;

    typedef struct packed {
        logic mult;
        logic multu;
        logic mfhi;
        logic mflo;
        logic mthi;
        logic mtlo;
    } hilo_op_t;

    typedef struct packed {
        alu_op_e                    alu_op;
        logic                       of_valid;  // add/sub trap on overflow
        logic                       src1_is_pc;
        logic                       src2_is_imm;
        logic                       src2_is_8;  // link address
        logic                       mem_re;
        logic                       mem_we;
        ls_type_t                   ls_type;
        logic                       gpr_we;
        logic [`EXE_REG_ADDR_W-1:0] dest;
        logic [`EXE_IMM_W-1:0]      imm;
        hilo_op_t                   hilo_op;
        logic [`EXE_XLEN-1:0]       rs_value;
        logic [`EXE_XLEN-1:0]       rt_value;
        logic [`EXE_XLEN-1:0]       pc;
    } ds_to_es_t;

    // alu output read as a value or as a memory address
    typedef union packed {
        logic [`EXE_XLEN-1:0] data;
        struct packed {
            logic [`EXE_XLEN-`EXE_LANE_W-1:0] index;
            logic [`EXE_LANE_W-1:0]           lane;
        } split;
    } exe_word_u;

    typedef struct packed {
        logic                       exc_of;
        logic                       exc_adel;
        logic                       exc_ades;
        logic [`EXE_XLEN-1:0]       badvaddr;
        ls_type_t                   ls_type;
        logic [`EXE_LANE_W-1:0]     lane;  // load alignment in mem stage
        logic                       mem_re;
        logic                       gpr_we;
        logic [`EXE_REG_ADDR_W-1:0] dest;
        logic [`EXE_XLEN-1:0]       rt_value;
        logic [`EXE_XLEN-1:0]       result;
        logic [`EXE_XLEN-1:0]       pc;
    } es_to_ms_t;

    typedef struct packed {
        logic                       valid;
        logic                       res_valid;  // low while a load is in flight
        logic [`EXE_REG_ADDR_W-1:0] dest;
        logic [`EXE_XLEN-1:0]       result;
    } es_bypass_t;

    typedef struct packed {
        logic                   wr;
        logic [1:0]             size;  // 0 byte, 1 half, 2 word
        logic [`EXE_XLEN-1:0]   addr;
        logic [`EXE_STRB_W-1:0] wstrb;
        logic [`EXE_XLEN-1:0]   wdata;
    } mem_req_t;

endpackage

//--- hw/exe_pipe_ctrl.sv
`timescale 1ns/1ps

module exe_pipe_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  exe_pkg::ds_to_es_t in_bus,
    output logic               in_allowin,
    input  logic               flush,
    input  logic               exc,
    input  logic               mem_done,
    input  logic               out_allowin,
    output logic               es_valid,
    output exe_pkg::ds_to_es_t inst,
    output logic               out_valid,
    output logic               ignore
);
    logic ready_go;
    logic pre_flush;  // exception seen and waiting for flush

    assign ready_go   = mem_done | flush;
    assign in_allowin = ~es_valid | (ready_go & out_allowin) | flush;
    assign out_valid  = es_valid & ready_go & ~flush;  // flushed inst dies here
    assign ignore     = flush | pre_flush | exc;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            inst <= in_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_flush <= 1'b0;
        end else if (flush) begin
            pre_flush <= 1'b0;
        end else if (es_valid && exc) begin
            pre_flush <= 1'b1;
        end
    end

    // a stalled output keeps its payload until taken or flushed
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !flush |=> flush || (out_valid && $stable(inst)));

endmodule

//--- hw/exe_alu.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_alu (
    input  exe_pkg::ds_to_es_t inst,
    output exe_pkg::exe_word_u result,
    output logic               overflow
);
    import exe_pkg::*;

    logic                 zero_ext;
    logic [`EXE_XLEN-1:0] imm_ext;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic [`EXE_XLEN-1:0] sum;
    logic [`EXE_XLEN-1:0] diff;
    logic                 add_of;
    logic                 sub_of;
    logic                 lt_signed;
    logic                 lt_unsigned;

    // andi/ori/xori take the immediate unsigned
    assign zero_ext = inst.alu_op inside {op_and, op_or, op_xor};
    assign imm_ext  = {{(`EXE_XLEN-`EXE_IMM_W){~zero_ext & inst.imm[`EXE_IMM_W-1]}},
                       inst.imm};

    assign src1 = inst.src1_is_pc  ? inst.pc        : inst.rs_value;
    assign src2 = inst.src2_is_imm ? imm_ext        :
                  inst.src2_is_8   ? `EXE_XLEN'(8)  : inst.rt_value;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign add_of = (src1[`EXE_XLEN-1] == src2[`EXE_XLEN-1])
                  & (sum[`EXE_XLEN-1] != src1[`EXE_XLEN-1]);
    assign sub_of = (src1[`EXE_XLEN-1] != src2[`EXE_XLEN-1])
                  & (diff[`EXE_XLEN-1] != src1[`EXE_XLEN-1]);

    // signs differ: the negative one is smaller
    assign lt_signed   = (src1[`EXE_XLEN-1] != src2[`EXE_XLEN-1]) ? src1[`EXE_XLEN-1]
                                                                  : diff[`EXE_XLEN-1];
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (inst.alu_op)
            op_add:  result.data = sum;
            op_sub:  result.data = diff;
            op_slt:  result.data = `EXE_XLEN'(lt_signed);
            op_sltu: result.data = `EXE_XLEN'(lt_unsigned);
            op_and:  result.data = src1 & src2;
            op_or:   result.data = src1 | src2;
            op_xor:  result.data = src1 ^ src2;
            op_lui:  result.data = {src2[`EXE_IMM_W-1:0], {(`EXE_XLEN-`EXE_IMM_W){1'b0}}};
            default: result.data = sum;
        endcase
    end

    assign overflow = inst.of_valid & ((inst.alu_op == op_add & add_of)
                                     | (inst.alu_op == op_sub & sub_of));

endmodule

//--- hw/exe_hilo_unit.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_hilo_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  exe_pkg::ds_to_es_t   inst,
    input  exe_pkg::exe_word_u   alu_result,
    input  logic                 es_valid,
    input  logic                 ignore,
    output logic [`EXE_XLEN-1:0] result
);
    logic [`EXE_XLEN-1:0]   hi;
    logic [`EXE_XLEN-1:0]   lo;
    logic [`EXE_XLEN:0]     mult_a;  // 33 bits, top is sign or zero
    logic [`EXE_XLEN:0]     mult_b;
    logic [2*`EXE_XLEN+1:0] product;
    logic                   write_ok;

    assign mult_a  = {inst.hilo_op.mult & inst.rs_value[`EXE_XLEN-1], inst.rs_value};
    assign mult_b  = {inst.hilo_op.mult & inst.rt_value[`EXE_XLEN-1], inst.rt_value};
    assign product = $signed(mult_a) * $signed(mult_b);

    assign write_ok = es_valid & ~ignore;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (write_ok) begin
            if (inst.hilo_op.mult || inst.hilo_op.multu) begin
                hi <= product[2*`EXE_XLEN-1:`EXE_XLEN];
                lo <= product[`EXE_XLEN-1:0];
            end else begin
                if (inst.hilo_op.mthi) begin
                    hi <= inst.rs_value;
                end
                if (inst.hilo_op.mtlo) begin
                    lo <= inst.rs_value;
                end
            end
        end
    end

    assign result = inst.hilo_op.mfhi ? hi :
                    inst.hilo_op.mflo ? lo : alu_result.data;

endmodule

//--- hw/exe_store_align.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_store_align (
    input  exe_pkg::ds_to_es_t     inst,
    input  exe_pkg::exe_word_u     addr,
    output logic [`EXE_STRB_W-1:0] wstrb,
    output logic [`EXE_XLEN-1:0]   wdata,
    output logic [1:0]             size,
    output logic                   exc_adel,
    output logic                   exc_ades
);
    logic [`EXE_LANE_W-1:0] lane;
    logic [`EXE_STRB_W-1:0] lane_oh;
    logic [2:0]             strb_cnt;
    logic                   misaligned;

    assign lane    = addr.split.lane;
    assign lane_oh = `EXE_STRB_W'(1) << lane;

    always_comb begin
        if (inst.ls_type.byte_) begin
            wstrb = lane_oh;
            wdata = {4{inst.rt_value[7:0]}};
        end else if (inst.ls_type.half) begin
            wstrb = lane[1] ? 4'b1100 : 4'b0011;
            wdata = {2{inst.rt_value[15:0]}};
        end else if (inst.ls_type.left) begin
            wstrb = (lane_oh << 1) - `EXE_STRB_W'(1);      // lanes 0..lane
            wdata = inst.rt_value >> {~lane, 3'b000};      // high bytes move down
        end else if (inst.ls_type.right) begin
            wstrb = ~(lane_oh - `EXE_STRB_W'(1));          // lanes lane..3
            wdata = inst.rt_value << {lane, 3'b000};
        end else begin
            wstrb = '1;  // sw
            wdata = inst.rt_value;
        end
    end

    assign strb_cnt = 3'($countones(wstrb));
    assign size     = (strb_cnt == 3'd1) ? 2'd0 :
                      (strb_cnt == 3'd2) ? 2'd1 : 2'd2;

    assign misaligned = (inst.ls_type.half & lane[0])
                      | (inst.ls_type.word & |lane);

    assign exc_adel = inst.mem_re & misaligned;
    assign exc_ades = inst.mem_we & misaligned;

endmodule

//--- hw/exe_mem_request.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_mem_request (
    input  logic                   clk,
    input  logic                   reset,
    input  exe_pkg::ds_to_es_t     inst,
    input  logic                   es_valid,
    input  logic                   ignore,
    input  logic                   out_valid,
    input  logic                   out_allowin,
    input  logic                   exc_addr,
    input  logic [`EXE_XLEN-1:0]   addr,
    input  logic [`EXE_STRB_W-1:0] wstrb,
    input  logic [`EXE_XLEN-1:0]   wdata,
    input  logic [1:0]             size,
    output logic                   mem_req,
    output exe_pkg::mem_req_t      mem,
    input  logic                   mem_addr_ok,
    output logic                   mem_done
);
    logic is_mem;
    logic addr_acc;  // address taken for the held inst
    logic wr;

    assign is_mem   = inst.mem_re | inst.mem_we;
    assign mem_done = ~is_mem | exc_addr | addr_acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_acc <= 1'b0;
        end else if (ignore) begin
            addr_acc <= 1'b0;
        end else if (out_valid && out_allowin) begin
            addr_acc <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            addr_acc <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req <= 1'b0;
        end else if (ignore) begin
            mem_req <= 1'b0;  // drop it, later stage will flush
        end else if (mem_req && mem_addr_ok) begin
            mem_req <= 1'b0;
        end else if (!mem_req && !addr_acc) begin
            mem_req <= es_valid & is_mem;
        end
    end

    assign wr = inst.mem_we & ~ignore;

    assign mem.wr    = wr;
    assign mem.size  = size;
    assign mem.addr  = addr;
    assign mem.wstrb = {`EXE_STRB_W{wr}} & wstrb;  // zero for loads
    assign mem.wdata = wdata;

    // pending request is kept, with its address, until memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_addr_ok && !ignore |=> mem_req && $stable(mem.addr));

endmodule

//--- hw/exe_stage.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  exe_pkg::ds_to_es_t  in_bus,
    output logic                in_allowin,
    output logic                out_valid,
    output exe_pkg::es_to_ms_t  out_bus,
    input  logic                out_allowin,
    output exe_pkg::es_bypass_t bypass,
    input  logic                flush,
    output logic                mem_req,
    output exe_pkg::mem_req_t   mem,
    input  logic                mem_addr_ok
);
    import exe_pkg::*;

    ds_to_es_t              inst;
    exe_word_u              alu_result;
    logic                   es_valid;
    logic                   ignore;
    logic                   exc;
    logic                   mem_done;
    logic                   overflow;
    logic                   exc_adel;
    logic                   exc_ades;
    logic [`EXE_XLEN-1:0]   result;
    logic [`EXE_STRB_W-1:0] wstrb;
    logic [`EXE_XLEN-1:0]   wdata;
    logic [1:0]             size;

    assign exc = overflow | exc_adel | exc_ades;

    exe_pipe_ctrl u_pipe_ctrl (
        .clk, .reset, .in_valid, .in_bus, .in_allowin, .flush, .exc,
        .mem_done, .out_allowin, .es_valid, .inst, .out_valid, .ignore
    );

    exe_alu u_alu (.inst, .result(alu_result), .overflow);

    exe_hilo_unit u_hilo (
        .clk, .reset, .inst, .alu_result, .es_valid, .ignore, .result
    );

    exe_store_align u_store_align (
        .inst, .addr(alu_result), .wstrb, .wdata, .size, .exc_adel, .exc_ades
    );

    exe_mem_request u_mem_request (
        .clk, .reset, .inst, .es_valid, .ignore, .out_valid, .out_allowin,
        .exc_addr(exc_adel | exc_ades), .addr(alu_result.data), .wstrb, .wdata,
        .size, .mem_req, .mem, .mem_addr_ok, .mem_done
    );

    always_comb begin
        out_bus.exc_of   = overflow;
        out_bus.exc_adel = exc_adel;
        out_bus.exc_ades = exc_ades;
        out_bus.badvaddr = alu_result.data;
        out_bus.ls_type  = inst.ls_type;
        out_bus.lane     = alu_result.split.lane;
        out_bus.mem_re   = inst.mem_re;
        out_bus.gpr_we   = inst.gpr_we;
        out_bus.dest     = inst.dest;
        out_bus.rt_value = inst.rt_value;
        out_bus.result   = result;
        out_bus.pc       = inst.pc;
    end

    always_comb begin
        bypass = '0;
        if (es_valid && inst.gpr_we) begin
            bypass.valid     = 1'b1;
            bypass.res_valid = ~inst.mem_re;  // load data not here yet
            bypass.dest      = inst.dest;
            bypass.result    = result;
        end
    end

endmodule

//--- tests/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb;
    import exe_pkg::*;

    localparam int max_cycles = 2000;  // about four times what the tests use
    localparam logic [31:0] base_addr  = 32'h1000_0040;
    localparam logic [31:0] store_word = 32'ha1b2_c3d4;

    localparam ls_type_t ls_word  = '{word: 1'b1, default: 1'b0};
    localparam ls_type_t ls_byte  = '{byte_: 1'b1, default: 1'b0};
    localparam ls_type_t ls_half  = '{half: 1'b1, default: 1'b0};
    localparam ls_type_t ls_left  = '{left: 1'b1, default: 1'b0};
    localparam ls_type_t ls_right = '{right: 1'b1, default: 1'b0};

    localparam hilo_op_t do_mult  = '{mult: 1'b1, default: 1'b0};
    localparam hilo_op_t do_multu = '{multu: 1'b1, default: 1'b0};
    localparam hilo_op_t do_mfhi  = '{mfhi: 1'b1, default: 1'b0};
    localparam hilo_op_t do_mflo  = '{mflo: 1'b1, default: 1'b0};
    localparam hilo_op_t do_mthi  = '{mthi: 1'b1, default: 1'b0};
    localparam hilo_op_t do_mtlo  = '{mtlo: 1'b1, default: 1'b0};

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    ds_to_es_t  in_bus;
    logic       in_allowin;
    logic       out_valid;
    es_to_ms_t  out_bus;
    logic       out_allowin;
    es_bypass_t bypass;
    logic       flush;
    logic       mem_req;
    mem_req_t   mem;
    logic       mem_addr_ok = 1'b0;

    integer     seed = 32'h0d0edc37;
    int         wait_cnt;
    int         cycles;
    int         checks;
    int         errors;
    int         test_errors;  // error count when the current test began

    es_to_ms_t  res_bus;  // captured at the handover to memory stage
    es_bypass_t res_byp;
    mem_req_t   res_mem;
    bit         acked;
    bit         req_seen;

    exe_stage dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run passed %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // data memory takes the address after a random wait
    always @(posedge clk) begin
        if (reset) begin
            mem_addr_ok <= 1'b0;
            wait_cnt    <= 1;
        end else if (mem_addr_ok) begin
            mem_addr_ok <= 1'b0;  // one-cycle pulse
        end else if (mem_req) begin
            if (wait_cnt == 0) begin
                mem_addr_ok <= 1'b1;
                wait_cnt    <= $random(seed) & 3;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    function automatic ds_to_es_t alu_inst(input alu_op_e op, input logic [31:0] rs,
                                           input logic [31:0] rt, input logic use_imm,
                                           input logic [15:0] imm);
        ds_to_es_t d;
        d = '0;
        d.alu_op      = op;
        d.rs_value    = rs;
        d.rt_value    = rt;
        d.src2_is_imm = use_imm;
        d.imm         = imm;
        d.gpr_we      = 1'b1;
        d.dest        = 5'd8;
        d.pc          = 32'hbfc0_0100;
        return d;
    endfunction

    function automatic ds_to_es_t mem_inst(input ls_type_t ls, input logic we,
                                           input logic [31:0] base, input logic [15:0] off,
                                           input logic [31:0] rt);
        ds_to_es_t d;
        d = alu_inst(op_add, base, rt, 1'b1, off);
        d.mem_we  = we;
        d.mem_re  = ~we;
        d.gpr_we  = ~we;
        d.ls_type = ls;
        return d;
    endfunction

    function automatic ds_to_es_t hilo_inst(input hilo_op_t h, input logic [31:0] rs,
                                            input logic [31:0] rt);
        ds_to_es_t d;
        d = alu_inst(op_add, rs, rt, 1'b0, 16'h0000);
        d.hilo_op = h;
        d.gpr_we  = h.mfhi | h.mflo;
        return d;
    endfunction

    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] x,
                                            input logic [31:0] y);
        case (op)
            op_add:  return x + y;
            op_sub:  return x - y;
            op_slt:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            op_sltu: return (x < y) ? 32'd1 : 32'd0;
            op_and:  return x & y;
            op_or:   return x | y;
            op_xor:  return x ^ y;
            default: return {y[15:0], 16'h0000};  // lui
        endcase
    endfunction

    function automatic logic ref_overflow(input logic is_sub, input logic [31:0] x,
                                          input logic [31:0] y);
        logic [32:0] wide;
        wide = is_sub ? {x[31], x} - {y[31], y} : {x[31], x} + {y[31], y};
        return wide[32] != wide[31];
    endfunction

    // hand one instruction in and wait until the stage hands it over
    task automatic run_inst(input ds_to_es_t d);
        @(posedge clk);
        in_valid <= 1'b1;
        in_bus   <= d;
        @(negedge clk);
        while (!in_allowin) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
        acked    = 1'b0;
        req_seen = 1'b0;
        @(negedge clk);
        while (!(out_valid && out_allowin)) begin
            req_seen |= mem_req;
            if (mem_req && mem_addr_ok) begin
                acked   = 1'b1;
                res_mem = mem;
            end
            @(negedge clk);
        end
        req_seen |= mem_req;
        res_bus = out_bus;
        res_byp = bypass;
    endtask

    task automatic pulse_flush;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic test_reset;
        @(negedge clk);
        check_val("out_valid", 160'(out_valid), 160'(1'b0));
        check_val("mem_req", 160'(mem_req), 160'(1'b0));
        check_val("in_allowin", 160'(in_allowin), 160'(1'b1));
    endtask

    task automatic test_alu;
        logic [31:0] a [4];
        logic [31:0] b [4];
        logic [31:0] ext;
        logic [31:0] exp;
        logic [15:0] imm;
        alu_op_e     op;
        int          k;
        int          i;
        a = '{32'd5, 32'h8000_0000, 32'hffff_fff0, 32'h1234_5678};
        b = '{32'd7, 32'd1, 32'h0000_8001, 32'h0f0f_f0f0};  // 8001 tests imm sign
        for (k = 0; k < 8; k++) begin
            op = alu_op_e'(k);
            for (i = 0; i < 4; i++) begin
                run_inst(alu_inst(op, a[i], b[i], 1'b0, 16'h0000));
                exp = ref_alu(op, a[i], b[i]);
                check_val("out_bus.result", 160'(res_bus.result), 160'(exp));
                check_val("bypass.result", 160'(res_byp.result), 160'(exp));
                check_val("bypass.valid", 160'(res_byp.valid), 160'(1'b1));
                check_val("bypass.dest", 160'(res_byp.dest), 160'(5'd8));
                check_val("out_bus.exc_of", 160'(res_bus.exc_of), 160'(1'b0));
                imm = b[i][15:0];
                ext = (op inside {op_and, op_or, op_xor}) ? {16'h0000, imm}
                                                           : {{16{imm[15]}}, imm};
                run_inst(alu_inst(op, a[i], 32'hdead_beef, 1'b1, imm));
                exp = ref_alu(op, a[i], ext);
                check_val("out_bus.result", 160'(res_bus.result), 160'(exp));
                check_val("bypass.result", 160'(res_byp.result), 160'(exp));
            end
        end
    endtask

    task automatic test_overflow;
        logic [31:0] a [4];
        logic [31:0] b [4];
        ds_to_es_t   d;
        int          s;
        int          i;
        a = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'd5};
        b = '{32'd1, 32'd1, 32'h8000_0000, 32'hffff_fffd};
        for (s = 0; s < 2; s++) begin
            for (i = 0; i < 4; i++) begin
                d = alu_inst((s == 1) ? op_sub : op_add, a[i], b[i], 1'b0, 16'h0000);
                d.of_valid = 1'b1;
                run_inst(d);
                check_val("out_bus.exc_of", 160'(res_bus.exc_of),
                          160'(ref_overflow(s == 1, a[i], b[i])));
                pulse_flush;  // clear the pending exception
                d.of_valid = 1'b0;
                run_inst(d);
                check_val("out_bus.exc_of", 160'(res_bus.exc_of), 160'(1'b0));
            end
        end
    endtask

    task automatic test_hilo;
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        logic [31:0]        x;
        logic [31:0]        y;
        x = 32'hfffe_1234;  // negative
        y = 32'h0003_8000;
        sprod = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
        uprod = {32'h0000_0000, x} * {32'h0000_0000, y};
        run_inst(hilo_inst(do_mult, x, y));
        run_inst(hilo_inst(do_mfhi, 32'd0, 32'd0));
        check_val("out_bus.result after mult, mfhi", 160'(res_bus.result), 160'(sprod[63:32]));
        run_inst(hilo_inst(do_mflo, 32'd0, 32'd0));
        check_val("out_bus.result after mult, mflo", 160'(res_bus.result), 160'(sprod[31:0]));
        run_inst(hilo_inst(do_multu, x, y));
        run_inst(hilo_inst(do_mfhi, 32'd0, 32'd0));
        check_val("out_bus.result after multu, mfhi", 160'(res_bus.result), 160'(uprod[63:32]));
        run_inst(hilo_inst(do_mflo, 32'd0, 32'd0));
        check_val("out_bus.result after multu, mflo", 160'(res_bus.result), 160'(uprod[31:0]));
        run_inst(hilo_inst(do_mthi, 32'h1111_2222, 32'd0));
        run_inst(hilo_inst(do_mfhi, 32'd0, 32'd0));
        check_val("out_bus.result after mthi, mfhi", 160'(res_bus.result), 160'(32'h1111_2222));
        run_inst(hilo_inst(do_mflo, 32'd0, 32'd0));
        check_val("out_bus.result after mthi, mflo", 160'(res_bus.result), 160'(uprod[31:0]));
        run_inst(hilo_inst(do_mtlo, 32'h3333_4444, 32'd0));
        run_inst(hilo_inst(do_mflo, 32'd0, 32'd0));
        check_val("out_bus.result after mtlo, mflo", 160'(res_bus.result), 160'(32'h3333_4444));
        run_inst(hilo_inst(do_mfhi, 32'd0, 32'd0));
        check_val("out_bus.result after mtlo, mfhi", 160'(res_bus.result), 160'(32'h1111_2222));
    endtask

    task automatic check_store(input string name, input ls_type_t ls, input int lane,
                               input logic [3:0] strb, input logic [31:0] data);
        logic [31:0] mask;
        logic [1:0]  size;
        int          ones;
        run_inst(mem_inst(ls, 1'b1, base_addr, 16'(lane), store_word));
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        ones = $countones(strb);
        size = (ones == 1) ? 2'd0 : (ones == 2) ? 2'd1 : 2'd2;
        check_val({name, " mem_addr_ok before out_valid"}, 160'(acked), 160'(1'b1));
        check_val({name, " mem.wr"}, 160'(res_mem.wr), 160'(1'b1));
        check_val({name, " mem.addr"}, 160'(res_mem.addr), 160'(base_addr + 32'(lane)));
        check_val({name, " mem.wstrb"}, 160'(res_mem.wstrb), 160'(strb));
        check_val({name, " mem.wdata"}, 160'(res_mem.wdata & mask), 160'(data));
        check_val({name, " mem.size"}, 160'(res_mem.size), 160'(size));
    endtask

    task automatic test_stores;
        int lane;
        for (lane = 0; lane < 4; lane++) begin
            check_store("sb", ls_byte, lane, 4'b0001 << lane,
                        {24'h000000, store_word[7:0]} << (8 * lane));
            check_store("swl", ls_left, lane, 4'b1111 >> (3 - lane),
                        store_word >> (8 * (3 - lane)));
            check_store("swr", ls_right, lane, 4'b1111 << lane,
                        store_word << (8 * lane));
        end
        check_store("sh", ls_half, 0, 4'b0011, {16'h0000, store_word[15:0]});
        check_store("sh", ls_half, 2, 4'b1100, {store_word[15:0], 16'h0000});
        check_store("sw", ls_word, 0, 4'b1111, store_word);
        run_inst(mem_inst(ls_word, 1'b0, base_addr, 16'd8, 32'd0));
        check_val("lw mem_addr_ok before out_valid", 160'(acked), 160'(1'b1));
        check_val("lw mem.wstrb", 160'(res_mem.wstrb), 160'(4'b0000));
        check_val("lw bypass.valid", 160'(res_byp.valid), 160'(1'b1));
        check_val("lw bypass.res_valid", 160'(res_byp.res_valid), 160'(1'b0));
    endtask

    task automatic test_addr_error;
        run_inst(hilo_inst(do_mthi, 32'h5a5a_0001, 32'd0));
        run_inst(mem_inst(ls_half, 1'b1, base_addr, 16'd1, store_word));
        check_val("sh out_bus.exc_ades", 160'(res_bus.exc_ades), 160'(1'b1));
        check_val("sh out_bus.exc_adel", 160'(res_bus.exc_adel), 160'(1'b0));
        check_val("sh out_bus.badvaddr", 160'(res_bus.badvaddr), 160'(base_addr + 32'd1));
        @(negedge clk);
        req_seen |= mem_req;  // a request would rise one cycle after the hold
        check_val("sh mem_req seen", 160'(req_seen), 160'(1'b0));
        pulse_flush;
        run_inst(mem_inst(ls_word, 1'b0, base_addr, 16'd2, 32'd0));
        check_val("lw out_bus.exc_adel", 160'(res_bus.exc_adel), 160'(1'b1));
        check_val("lw out_bus.badvaddr", 160'(res_bus.badvaddr), 160'(base_addr + 32'd2));
        @(negedge clk);
        req_seen |= mem_req;
        check_val("lw mem_req seen", 160'(req_seen), 160'(1'b0));
        run_inst(hilo_inst(do_mthi, 32'hdead_0002, 32'd0));  // dropped while flush pending
        pulse_flush;
        run_inst(hilo_inst(do_mfhi, 32'd0, 32'd0));
        check_val("out_bus.result after flush, mfhi", 160'(res_bus.result),
                  160'(32'h5a5a_0001));
    endtask

    task automatic test_backpressure;
        es_to_ms_t   held;
        logic [31:0] got [$];
        bit          drop;
        @(posedge clk);
        out_allowin <= 1'b0;
        in_valid    <= 1'b1;
        in_bus      <= alu_inst(op_add, 32'd100, 32'd1, 1'b0, 16'h0000);
        @(negedge clk);
        while (!in_allowin) @(negedge clk);
        @(posedge clk);
        in_bus <= alu_inst(op_sub, 32'd100, 32'd1, 1'b0, 16'h0000);  // has to wait
        @(negedge clk);
        held = out_bus;
        repeat (5) begin
            check_val("out_valid", 160'(out_valid), 160'(1'b1));
            check_val("in_allowin", 160'(in_allowin), 160'(1'b0));
            check_val("out_bus", 160'(out_bus), 160'(held));
            @(negedge clk);
        end
        @(posedge clk);
        out_allowin <= 1'b1;
        repeat (4) begin  // window longer than two transfers
            @(negedge clk);
            if (out_valid && out_allowin) begin
                got.push_back(out_bus.result);
            end
            drop = in_valid && in_allowin;
            @(posedge clk);
            if (drop) begin
                in_valid <= 1'b0;
            end
        end
        check_val("delivered count", 160'(got.size()), 160'(2));
        if (got.size() == 2) begin
            check_val("first out_bus.result", 160'(got[0]),
                      160'(ref_alu(op_add, 32'd100, 32'd1)));
            check_val("second out_bus.result", 160'(got[1]),
                      160'(ref_alu(op_sub, 32'd100, 32'd1)));
        end
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        out_allowin = 1'b1;
        flush       = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset;
        end_test("reset");
        test_alu;
        end_test("alu");
        test_overflow;
        end_test("overflow");
        test_hilo;
        end_test("hilo");
        test_stores;
        end_test("stores");
        test_addr_error;
        end_test("address error");
        test_backpressure;
        end_test("backpressure");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- exe_stage.f
+incdir+include
hw/exe_pkg.sv
hw/exe_pipe_ctrl.sv
hw/exe_alu.sv
hw/exe_hilo_unit.sv
hw/exe_store_align.sv
hw/exe_mem_request.sv
hw/exe_stage.sv
tests/exe_stage_tb.sv

//--- Makefile
SIM = obj_dir/Vexe_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 -f exe_stage.f --top-module exe_stage_tb
	@out=$$(./$(SIM)); echo "$$out"; \
	echo "$$out" | grep -qF "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
